// ==== src/fmc_i2c_pkg.sv ====
package fmc_i2c_pkg;

    ////////////////////////////////////////
    // Widths that carry a meaning
    ////////////////////////////////////////

    // One byte on the I2C bus
    typedef logic [7:0] i2c_byte_t;

    // Pointer into the configuration table
    typedef logic [2:0] cfg_idx_t;

    // Half period and hold delay counter
    typedef logic [10:0] half_cnt_t;

    ////////////////////////////////////////
    // Bus timing
    ////////////////////////////////////////

    // 250 MHz system clock, 100 kHz SCL
    localparam int SCL_HALF_CYCLES = 1250;
    // Data hold after SCL is pulled low, roughly 48 ns
    localparam int SDA_HOLD_CYCLES = 12;
    // Read-back synchronizer depth
    localparam int SYNC_STAGES     = 2;

    ////////////////////////////////////////
    // Configuration sequence
    ////////////////////////////////////////

    localparam int CFG_LEN   = 5;
    // First byte of the second transaction
    localparam int CFG_SPLIT = 2;

    // Bus switch first, then the logic device control register
    localparam i2c_byte_t CFG_TABLE [CFG_LEN] = '{
        8'hE2,  // Bus switch address, write
        8'h80,  // Channel select
        8'h7C,  // Logic device address, write
        8'h02,  // Control register index
        8'h01   // Control value
    };

    // Commands from the sequencer to the bit engine
    typedef enum logic [1:0] {CMD_START, CMD_BYTE, CMD_STOP} bit_cmd_e;

    typedef enum logic [2:0] {SEQ_IDLE, SEQ_START, SEQ_BYTE, SEQ_STOP, SEQ_NEXT} seq_state_e;

    typedef enum logic [2:0] {
        BIT_IDLE, BIT_START, BIT_LOW, BIT_HIGH, BIT_STOP, BIT_DONE
    } bit_state_e;

endpackage

// ==== src/i2c_line_sync.sv ====
`timescale 1ns/1ps

module i2c_line_sync (
    input  logic CLK,
    input  logic reset,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_level_o,
    output logic sda_level_o
);
    import fmc_i2c_pkg::*;

    ////////////////////////////////////////
    // Flop chains for the pin read-back
    ////////////////////////////////////////

    // Newest sample sits in bit 0
    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] sda_sync;

    always_ff @(posedge CLK) begin
        if (reset) begin
            // Idle bus reads high on both lines
            scl_sync <= '1;
            sda_sync <= '1;
        end else begin
            scl_sync <= {scl_sync[SYNC_STAGES-2:0], scl_i};
            sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda_i};
        end
    end

    // Oldest stage feeds the bit engine
    assign scl_level_o = scl_sync[SYNC_STAGES-1];
    assign sda_level_o = sda_sync[SYNC_STAGES-1];

endmodule

// ==== src/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   cmd_valid_i,
    input  fmc_i2c_pkg::bit_cmd_e  cmd_i,
    input  fmc_i2c_pkg::i2c_byte_t cmd_byte_i,
    input  logic                   scl_level_i,
    input  logic                   sda_level_i,
    output logic                   cmd_done_o,
    output logic                   ack_ok_o,
    output logic                   scl_oe_o,
    output logic                   sda_oe_o
);
    import fmc_i2c_pkg::*;

    bit_state_e state;
    half_cnt_t  timer;
    // Bits 0 to 7 are data, bit 8 is the ACK clock
    logic [3:0] bit_cnt;
    // Second step of START and STOP
    logic       phase;
    i2c_byte_t  shift_reg;

    logic timer_end;
    logic hold_hit;
    logic mid_hit;
    logic ack_bit;
    logic shift_step;

    assign timer_end = (timer == half_cnt_t'(SCL_HALF_CYCLES - 1));
    assign hold_hit  = (timer == half_cnt_t'(SDA_HOLD_CYCLES));
    assign mid_hit   = (timer == half_cnt_t'(SCL_HALF_CYCLES / 2));
    assign ack_bit   = (bit_cnt == 4'd8);

    // Move to the next data bit at the end of its high phase
    assign shift_step = (state == BIT_HIGH) && scl_level_i && timer_end && !ack_bit;

    assign cmd_done_o = (state == BIT_DONE);

    ////////////////////////////////////////
    // Data shift register, MSB goes first
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if ((state == BIT_IDLE) && cmd_valid_i) begin
            shift_reg <= cmd_byte_i;
        end else if (shift_step) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    ////////////////////////////////////////
    // Bus timing FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            state    <= BIT_IDLE;
            timer    <= '0;
            bit_cnt  <= '0;
            phase    <= 1'b0;
            ack_ok_o <= 1'b0;
            // Both lines released
            scl_oe_o <= 1'b0;
            sda_oe_o <= 1'b0;
        end else begin
            case (state)
                BIT_IDLE: begin
                    timer   <= '0;
                    bit_cnt <= '0;
                    phase   <= 1'b0;
                    if (cmd_valid_i) begin
                        case (cmd_i)
                            CMD_START: state <= BIT_START;
                            CMD_BYTE: begin
                                ack_ok_o <= 1'b0;
                                state    <= BIT_LOW;
                            end
                            default:   state <= BIT_STOP;
                        endcase
                    end
                end

                BIT_START: begin
                    if (!phase) begin
                        // Bus must read free for a full half period
                        if (scl_level_i && sda_level_i) begin
                            if (timer_end) begin
                                timer    <= '0;
                                sda_oe_o <= 1'b1;
                                phase    <= 1'b1;
                            end else begin
                                timer <= timer + 1'b1;
                            end
                        end else begin
                            timer <= '0;
                        end
                    end else if (timer_end) begin
                        // SDA already low, now take SCL low
                        timer    <= '0;
                        scl_oe_o <= 1'b1;
                        state    <= BIT_DONE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end

                BIT_LOW: begin
                    // SDA moves only after the hold delay
                    if (hold_hit) begin
                        // Release SDA for the target's ACK
                        sda_oe_o <= ack_bit ? 1'b0 : ~shift_reg[7];
                    end
                    if (timer_end) begin
                        timer    <= '0;
                        scl_oe_o <= 1'b0;
                        state    <= BIT_HIGH;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end

                BIT_HIGH: begin
                    // Timer holds at zero while a target stretches SCL
                    if (scl_level_i) begin
                        if (ack_bit && mid_hit) begin
                            ack_ok_o <= ~sda_level_i;
                        end
                        if (timer_end) begin
                            timer    <= '0;
                            scl_oe_o <= 1'b1;
                            if (ack_bit) begin
                                state <= BIT_DONE;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                state   <= BIT_LOW;
                            end
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end
                end

                BIT_STOP: begin
                    if (!phase) begin
                        // SDA low during the SCL low phase
                        if (hold_hit) begin
                            sda_oe_o <= 1'b1;
                        end
                        if (timer_end) begin
                            timer    <= '0;
                            scl_oe_o <= 1'b0;
                            phase    <= 1'b1;
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end else if (scl_level_i) begin
                        // SDA rises with SCL high
                        if (timer_end) begin
                            timer    <= '0;
                            sda_oe_o <= 1'b0;
                            state    <= BIT_DONE;
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end
                end

                // One cycle of cmd_done_o
                BIT_DONE: state <= BIT_IDLE;

                default: state <= BIT_IDLE;
            endcase
        end
    end

endmodule

// ==== src/i2c_write_sequencer.sv ====
`timescale 1ns/1ps

module i2c_write_sequencer (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   start_i,
    input  logic                   cmd_done_i,
    input  logic                   ack_ok_i,
    output logic                   cmd_valid_o,
    output fmc_i2c_pkg::bit_cmd_e  cmd_o,
    output fmc_i2c_pkg::i2c_byte_t cmd_byte_o,
    output logic                   busy_o,
    output logic                   done_o,
    output logic                   nack_o
);
    import fmc_i2c_pkg::*;

    seq_state_e state;
    // Table entry currently on the bus
    cfg_idx_t   idx;
    cfg_idx_t   idx_next;
    logic       tr_last;
    logic       seq_end;

    assign idx_next = idx + cfg_idx_t'(1);

    // Next entry starts a new transaction or lies past the table
    assign tr_last = (idx_next == cfg_idx_t'(CFG_SPLIT)) ||
                     (idx_next == cfg_idx_t'(CFG_LEN));

    // After a NACK or the last byte the STOP ends the run
    assign seq_end = nack_o || (idx == cfg_idx_t'(CFG_LEN));

    // Byte for the engine, read straight from the table
    assign cmd_byte_o = (idx < cfg_idx_t'(CFG_LEN)) ? CFG_TABLE[idx] : '0;

    ////////////////////////////////////////
    // Sequence FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            state       <= SEQ_IDLE;
            idx         <= '0;
            cmd_valid_o <= 1'b0;
            cmd_o       <= CMD_START;
            busy_o      <= 1'b0;
            done_o      <= 1'b0;
            nack_o      <= 1'b0;
        end else begin
            // Strobes last one cycle
            cmd_valid_o <= 1'b0;
            done_o      <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start_i) begin
                        idx         <= '0;
                        nack_o      <= 1'b0;
                        busy_o      <= 1'b1;
                        cmd_valid_o <= 1'b1;
                        cmd_o       <= CMD_START;
                        state       <= SEQ_START;
                    end
                end

                // START of either transaction in flight
                SEQ_START, SEQ_NEXT: begin
                    if (cmd_done_i) begin
                        cmd_valid_o <= 1'b1;
                        cmd_o       <= CMD_BYTE;
                        state       <= SEQ_BYTE;
                    end
                end

                SEQ_BYTE: begin
                    if (cmd_done_i) begin
                        cmd_valid_o <= 1'b1;
                        if (!ack_ok_i) begin
                            // Skip the rest and close the bus
                            nack_o <= 1'b1;
                            cmd_o  <= CMD_STOP;
                            state  <= SEQ_STOP;
                        end else if (tr_last) begin
                            idx   <= idx_next;
                            cmd_o <= CMD_STOP;
                            state <= SEQ_STOP;
                        end else begin
                            idx   <= idx_next;
                            cmd_o <= CMD_BYTE;
                        end
                    end
                end

                SEQ_STOP: begin
                    if (cmd_done_i) begin
                        if (seq_end) begin
                            busy_o <= 1'b0;
                            done_o <= 1'b1;
                            state  <= SEQ_IDLE;
                        end else begin
                            // Second transaction opens right away
                            cmd_valid_o <= 1'b1;
                            cmd_o       <= CMD_START;
                            state       <= SEQ_NEXT;
                        end
                    end
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== src/fmc_i2c_controller.sv ====
`timescale 1ns/1ps

module fmc_i2c_controller (
    input  logic CLK,
    input  logic reset,
    input  logic start_i,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_oe_o,
    output logic sda_oe_o,
    output logic busy_o,
    output logic done_o,
    output logic nack_o
);
    import fmc_i2c_pkg::*;

    // Synced read-back
    logic      scl_level;
    logic      sda_level;

    // Sequencer to engine
    logic      cmd_valid;
    bit_cmd_e  cmd;
    i2c_byte_t cmd_byte;

    // Engine to sequencer
    logic      cmd_done;
    logic      ack_ok;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    i2c_line_sync i_line_sync (
        .CLK         (CLK),
        .reset       (reset),
        .scl_i       (scl_i),
        .sda_i       (sda_i),
        .scl_level_o (scl_level),
        .sda_level_o (sda_level)
    );

    // Walks the configuration table
    i2c_write_sequencer i_sequencer (
        .CLK         (CLK),
        .reset       (reset),
        .start_i     (start_i),
        .cmd_done_i  (cmd_done),
        .ack_ok_i    (ack_ok),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd),
        .cmd_byte_o  (cmd_byte),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .nack_o      (nack_o)
    );

    // Output side, owns the SCL and SDA timing
    i2c_bit_engine i_bit_engine (
        .CLK         (CLK),
        .reset       (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .cmd_byte_i  (cmd_byte),
        .scl_level_i (scl_level),
        .sda_level_i (sda_level),
        .cmd_done_o  (cmd_done),
        .ack_ok_o    (ack_ok),
        .scl_oe_o    (scl_oe_o),
        .sda_oe_o    (sda_oe_o)
    );

endmodule

// ==== tb/i2c_target_model.sv ====
`timescale 1ns/1ps

module i2c_target_model (
    input  logic CLK,
    input  logic reset,
    input  logic clear_i,
    input  int   nack_idx_i,
    input  int   stretch_i,
    input  logic scl_oe_i,
    input  logic sda_oe_i,
    output logic scl_o,
    output logic sda_o
);

    // Target side pull-downs
    logic       scl_hold;
    logic       sda_ack;
    // Bus levels one cycle back, for edge detection
    logic       scl_q;
    logic       sda_q;
    logic       in_frame;
    logic [7:0] shift;
    int         bit_cnt;
    int         byte_idx;
    int         stretch_cnt;
    int         start_count;
    int         stop_count;
    logic [7:0] rx_bytes [$];

    // Open-drain lines with pull-ups
    assign scl_o = !(scl_oe_i || scl_hold);
    assign sda_o = !(sda_oe_i || sda_ack);

    always @(posedge CLK) begin
        if (reset || clear_i) begin
            scl_hold    <= 1'b0;
            sda_ack     <= 1'b0;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            in_frame    <= 1'b0;
            shift       <= '0;
            bit_cnt     <= 0;
            byte_idx    <= 0;
            stretch_cnt <= 0;
            start_count <= 0;
            stop_count  <= 0;
            rx_bytes.delete();
        end else begin
            scl_q <= scl_o;
            sda_q <= sda_o;
            if (scl_o && scl_q && sda_q && !sda_o) begin
                // START, SDA falls with SCL high
                start_count <= start_count + 1;
                in_frame    <= 1'b1;
                bit_cnt     <= 0;
            end else if (scl_o && scl_q && !sda_q && sda_o) begin
                // STOP, SDA rises with SCL high
                stop_count <= stop_count + 1;
                in_frame   <= 1'b0;
            end else if (in_frame && !scl_q && scl_o) begin
                // Data is taken on the SCL rise
                if (bit_cnt < 8) begin
                    shift <= {shift[6:0], sda_o};
                end
                bit_cnt <= bit_cnt + 1;
            end else if (in_frame && scl_q && !scl_o) begin
                if (bit_cnt == 8) begin
                    // Byte complete, answer on the ninth clock
                    rx_bytes.push_back(shift);
                    sda_ack  <= (byte_idx != nack_idx_i);
                    byte_idx <= byte_idx + 1;
                end else if (bit_cnt == 9) begin
                    // ACK clock over, hold SCL low for a while
                    sda_ack <= 1'b0;
                    bit_cnt <= 0;
                    if (stretch_i > 0) begin
                        scl_hold    <= 1'b1;
                        stretch_cnt <= stretch_i;
                    end
                end
            end
            if (scl_hold) begin
                if (stretch_cnt <= 1) begin
                    scl_hold <= 1'b0;
                end
                stretch_cnt <= stretch_cnt - 1;
            end
        end
    end

endmodule

// ==== tb/fmc_i2c_controller_sva.sv ====
`timescale 1ns/1ps

module fmc_i2c_controller_sva (
    input logic                      CLK,
    input logic                      reset,
    input logic                      scl_oe_i,
    input logic                      sda_oe_i,
    input logic                      busy_i,
    input logic                      done_i,
    input logic                      nack_i,
    input fmc_i2c_pkg::bit_state_e   eng_state_i
);
    import fmc_i2c_pkg::*;

    // Failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    done_one_cycle: assert property (@(posedge CLK) disable iff (reset) done_i |=> !done_i)
        else begin
            fail_count++;
            $error("done_o wider than one cycle");
        end

    // busy_o falls in the cycle of done_o
    busy_low_at_done: assert property (@(posedge CLK) disable iff (reset) done_i |-> !busy_i)
        else begin
            fail_count++;
            $error("busy_o still high with done_o");
        end

    nack_stable_idle: assert property (@(posedge CLK) disable iff (reset)
        (!busy_i && $past(!busy_i)) |-> $stable(nack_i))
        else begin
            fail_count++;
            $error("nack_o changed while idle");
        end

    // With SCL released SDA may only move for START or STOP
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (reset)
        (!scl_oe_i && $past(!scl_oe_i) && $changed(sda_oe_i))
        |-> ($past(eng_state_i) inside {BIT_START, BIT_STOP}))
        else begin
            fail_count++;
            $error("SDA changed while SCL high outside START and STOP");
        end

endmodule

bind fmc_i2c_controller fmc_i2c_controller_sva i_sva (
    .CLK         (CLK),
    .reset       (reset),
    .scl_oe_i    (scl_oe_o),
    .sda_oe_i    (sda_oe_o),
    .busy_i      (busy_o),
    .done_i      (done_o),
    .nack_i      (nack_o),
    .eng_state_i (i_bit_engine.state)
);

// ==== tb/tb_fmc_i2c_controller.sv ====
`timescale 1ns/1ps

module tb_fmc_i2c_controller;
    import fmc_i2c_pkg::*;

    localparam int NUM_ROWS       = 9;
    localparam int NO_NACK        = -1;
    localparam int RANDOM_STRETCH = -1;
    // Random stretch lies in 1000 to 2023 cycles
    localparam int MAX_STRETCH    = 2100;
    // Nine clocks per byte and five stretches per row with a margin of two
    localparam int ROW_CYCLES     = 2 * (5 * 9 * 2 * SCL_HALF_CYCLES + 5 * MAX_STRETCH);
    localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES + 100;
    localparam logic [31:0] SEED  = 32'h1ca85037;

    typedef struct packed {
        int          nack_idx;
        int          stretch;
        logic        busy_start;
        int          n_bytes;
        logic [39:0] bytes;
        logic        exp_nack;
        int          exp_starts;
        int          exp_stops;
    } row_t;

    logic CLK;
    logic reset;
    logic start_i;
    logic clear;
    int   nack_idx;
    int   stretch_cfg;
    logic scl_bus;
    logic sda_bus;
    logic scl_oe;
    logic sda_oe;
    logic busy_o;
    logic done_o;
    logic nack_o;
    int   done_count;
    logic [31:0] lfsr;
    row_t rows [NUM_ROWS];

    fmc_i2c_controller i_dut (
        .CLK      (CLK),
        .reset    (reset),
        .start_i  (start_i),
        .scl_i    (scl_bus),
        .sda_i    (sda_bus),
        .scl_oe_o (scl_oe),
        .sda_oe_o (sda_oe),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .nack_o   (nack_o)
    );

    i2c_target_model i_target (
        .CLK        (CLK),
        .reset      (reset),
        .clear_i    (clear),
        .nack_idx_i (nack_idx),
        .stretch_i  (stretch_cfg),
        .scl_oe_i   (scl_oe),
        .sda_oe_i   (sda_oe),
        .scl_o      (scl_bus),
        .sda_o      (sda_bus)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (done_o) begin
            done_count++;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   stretch;
        row     = rows[r];
        stretch = row.stretch;
        if (stretch == RANDOM_STRETCH) begin
            stretch = 1000 + take_bits(10);
        end
        @(posedge CLK);
        #1;
        nack_idx    = row.nack_idx;
        stretch_cfg = stretch;
        clear       = 1'b1;
        @(posedge CLK);
        #1;
        clear      = 1'b0;
        done_count = 0;
        start_i    = 1'b1;
        @(posedge CLK);
        #1;
        start_i = 1'b0;
        check("busy_o", busy_o, 1'b1);
        // Accepted start clears the old NACK
        check("nack_o", nack_o, 1'b0);
        if (row.busy_start) begin
            repeat (3000) @(posedge CLK);
            #1;
            start_i = 1'b1;
            @(posedge CLK);
            #1;
            start_i = 1'b0;
        end
        do begin
            @(posedge CLK);
            #1;
        end while (!done_o);
        check("busy_o", busy_o, 1'b0);
        check("nack_o", nack_o, row.exp_nack);
        repeat (20) @(posedge CLK);
        #1;
        check("done_count", done_count, 1);
        check("busy_o", busy_o, 1'b0);
        check("start_count", i_target.start_count, row.exp_starts);
        check("stop_count", i_target.stop_count, row.exp_stops);
        check("rx_count", i_target.rx_bytes.size(), row.n_bytes);
        for (int i = 0; i < row.n_bytes; i++) begin
            check($sformatf("rx_byte[%0d]", i), i_target.rx_bytes[i],
                  row.bytes[39 - 8 * i -: 8]);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus table and main flow
    ////////////////////////////////////////

    initial begin
        // NACK index, stretch, busy start, byte count, bytes, NACK, STARTs, STOPs
        rows[0] = '{NO_NACK, 0, 1'b0, 5, 40'hE2807C0201, 1'b0, 2, 2};
        rows[1] = '{0, 0, 1'b0, 1, 40'hE200000000, 1'b1, 1, 1};
        rows[2] = '{NO_NACK, 0, 1'b0, 5, 40'hE2807C0201, 1'b0, 2, 2};
        rows[3] = '{1, 0, 1'b0, 2, 40'hE280000000, 1'b1, 1, 1};
        rows[4] = '{2, 0, 1'b0, 3, 40'hE2807C0000, 1'b1, 2, 2};
        rows[5] = '{4, 0, 1'b0, 5, 40'hE2807C0201, 1'b1, 2, 2};
        rows[6] = '{NO_NACK, RANDOM_STRETCH, 1'b0, 5, 40'hE2807C0201, 1'b0, 2, 2};
        rows[7] = '{3, 2000, 1'b0, 4, 40'hE2807C0200, 1'b1, 2, 2};
        rows[8] = '{NO_NACK, 0, 1'b1, 5, 40'hE2807C0201, 1'b0, 2, 2};

        done_count  = 0;
        lfsr        = SEED;
        reset       = 1'b1;
        start_i     = 1'b0;
        clear       = 1'b0;
        nack_idx    = NO_NACK;
        stretch_cfg = 0;
        repeat (8) @(posedge CLK);
        #1;
        reset = 1'b0;
        // Bus released and flags low out of reset
        check("scl_oe_o", scl_oe, 1'b0);
        check("sda_oe_o", sda_oe, 1'b0);
        check("busy_o", busy_o, 1'b0);
        check("done_o", done_o, 1'b0);
        check("nack_o", nack_o, 1'b0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        // Bound assertions report through their own failure count
        if (i_dut.i_sva.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "Bound assertions on the DUT outputs failed");
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("Watchdog expired, the rows did not finish in time");
        $display("RESULT: FAIL");
        $fatal(1, "Simulation timed out");
    end

endmodule

// ==== filelist.f ====
src/fmc_i2c_pkg.sv
src/i2c_line_sync.sv
src/i2c_bit_engine.sv
src/i2c_write_sequencer.sv
src/fmc_i2c_controller.sv
tb/i2c_target_model.sv
tb/fmc_i2c_controller_sva.sv
tb/tb_fmc_i2c_controller.sv

// ==== Bender.yml ====
package:
  name: fmc_i2c_controller

sources:
  - src/fmc_i2c_pkg.sv
  - src/i2c_line_sync.sv
  - src/i2c_bit_engine.sv
  - src/i2c_write_sequencer.sv
  - src/fmc_i2c_controller.sv
  - target: test
    files:
      - tb/i2c_target_model.sv
      - tb/fmc_i2c_controller_sva.sv
      - tb/tb_fmc_i2c_controller.sv
